// File: Bender.yml
package:
  name: dm_cache

sources:
  - files:
      - hdl/cache_pkg.sv
      - hdl/write_lane.sv
      - hdl/tag_store.sv
      - hdl/line_store.sv
      - hdl/cache_controller.sv
      - hdl/cache_top.sv
  - target: test
    files:
      - verif/cache_properties.sv
      - verif/cache_tb.sv

// File: hdl/cache_controller.sv
//################################################
// cache controller
// FSM for read hit, line fill and write-through
//################################################
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  r_en,
    input  cache_pkg::byte_mask_t w_en,
    input  logic                  hit,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    output logic                  r_ready,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output logic                  w_valid,
    input  logic                  w_ready,
    input  logic                  b_valid,
    output logic                  b_ready,
    output logic                  fill_en,
    output logic                  merge_en,
    output logic                  ready
);

    typedef enum logic [2:0] {
        idle,
        read_hit,
        read_addr,
        read_fill,
        write_send,
        write_resp_hit,
        write_resp_miss
    } state_t;

    state_t state;
    state_t next_state;
    logic   was_hit;       // hit seen when the write was sampled
    logic   wr_req;

    assign wr_req = |w_en;

    //################################################
    // state register
    //################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            was_hit <= 1'b0;
        end else begin
            state <= next_state;
            if (state == idle) begin
                was_hit <= hit;
            end
        end
    end

    //################################################
    // next state
    //################################################
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (r_en) begin
                    next_state = hit ? read_hit : read_addr;   // read wins if both set
                end else if (wr_req) begin
                    next_state = write_send;
                end
            end
            read_hit:  next_state = idle;
            read_addr: if (ar_ready) next_state = read_fill;
            read_fill: if (r_valid) next_state = read_hit;     // reread the filled line
            write_send: begin
                // aw and w retire together
                if (aw_ready && w_ready) begin
                    next_state = was_hit ? write_resp_hit : write_resp_miss;
                end
            end
            write_resp_hit:  if (b_valid) next_state = idle;
            write_resp_miss: if (b_valid) next_state = idle;
            default:         next_state = idle;
        endcase
    end

    //################################################
    // outputs
    //################################################
    always_comb begin
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        fill_en  = 1'b0;
        merge_en = 1'b0;
        ready    = 1'b0;
        case (state)
            read_hit:  ready = 1'b1;
            read_addr: ar_valid = 1'b1;
            read_fill: begin
                r_ready = 1'b1;
                fill_en = r_valid;     // tag, valid and data in one edge
            end
            write_send: begin
                aw_valid = 1'b1;
                w_valid  = 1'b1;
            end
            write_resp_hit: begin
                b_ready  = 1'b1;
                merge_en = b_valid;    // line updated once memory accepted
                ready    = b_valid;
            end
            write_resp_miss: begin
                b_ready = 1'b1;
                ready   = b_valid;     // no allocation
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
//################################################
// cache package
// geometry, address field types and port structs
//################################################
`default_nettype none

package cache_pkg;

    //################################################
    // geometry
    //################################################
    localparam int addr_w         = 16;
    localparam int word_w         = 32;
    localparam int offset_w       = 4;                // byte within a line
    localparam int index_w        = 4;                // 16 lines
    localparam int tag_w          = 8;
    localparam int line_bytes     = 16;
    localparam int line_w         = line_bytes * 8;   // 128 bits
    localparam int words_per_line = line_w / word_w;  // 4 words
    localparam int bus_addr_w     = 32;

    //################################################
    // field types
    //################################################
    typedef logic [addr_w-1:0]                     addr_t;
    typedef logic [tag_w-1:0]                      tag_t;
    typedef logic [index_w-1:0]                    index_t;
    typedef logic [$clog2(words_per_line)-1:0]     word_sel_t;
    typedef logic [word_w/8-1:0]                   byte_mask_t;
    typedef logic [word_w-1:0]                     word_t;
    typedef logic [line_w-1:0]                     line_t;
    typedef logic [line_bytes-1:0]                 line_strb_t;

    //################################################
    // port structs
    //################################################
    typedef struct packed {
        logic       r_en;
        byte_mask_t w_en;    // nonzero means write
        addr_t      addr;
        word_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  ready;        // one cycle pulse
    } cpu_rsp_t;

    typedef struct packed {
        logic [bus_addr_w-1:0] addr;
        logic                  valid;
    } mem_addr_t;            // shared by ar and aw

    typedef struct packed {
        line_t data;
        logic  valid;
    } mem_rdata_t;

    typedef struct packed {
        line_t      data;
        line_strb_t strb;
        logic       valid;
    } mem_wdata_t;

endpackage

`default_nettype wire

// File: hdl/cache_top.sv
//################################################
// cache top
// direct-mapped write-through cache, 16 x 16 byte
//################################################
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   req,
    output cache_pkg::cpu_rsp_t   rsp,
    output cache_pkg::mem_addr_t  ar,
    input  logic                  ar_ready,
    input  cache_pkg::mem_rdata_t r,
    output logic                  r_ready,
    output cache_pkg::mem_addr_t  aw,
    input  logic                  aw_ready,
    output cache_pkg::mem_wdata_t w,
    input  logic                  w_ready,
    input  logic                  b_valid,
    output logic                  b_ready
);

    localparam int sel_lsb = $clog2(cache_pkg::word_w / 8);

    //################################################
    // address split
    //################################################
    cache_pkg::tag_t              tag;
    cache_pkg::index_t            index;
    cache_pkg::word_sel_t         word_sel;
    logic [cache_pkg::bus_addr_w-1:0] line_addr;

    assign tag      = req.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
    assign index    = req.addr[cache_pkg::offset_w +: cache_pkg::index_w];
    assign word_sel = req.addr[sel_lsb +: $bits(cache_pkg::word_sel_t)];
    // line aligned, zero extended
    assign line_addr = {{(cache_pkg::bus_addr_w - cache_pkg::addr_w){1'b0}},
                        req.addr[cache_pkg::addr_w-1:cache_pkg::offset_w],
                        {cache_pkg::offset_w{1'b0}}};

    //################################################
    // internal nets
    //################################################
    cache_pkg::line_t      lane_line;
    cache_pkg::line_strb_t lane_strb;
    cache_pkg::word_t      rdata;
    logic                  hit;
    logic                  fill_en;
    logic                  merge_en;
    logic                  ready;
    logic                  ar_valid;
    logic                  aw_valid;
    logic                  w_valid;

    write_lane u_write_lane (
        .w_en     (req.w_en),
        .word_sel (word_sel),
        .wdata    (req.wdata),
        .line     (lane_line),
        .strb     (lane_strb)
    );

    tag_store u_tag_store (
        .clk     (clk),
        .rst     (rst),
        .index   (index),
        .tag     (tag),
        .fill_en (fill_en),
        .hit     (hit)
    );

    line_store u_line_store (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .word_sel   (word_sel),
        .fill_en    (fill_en),
        .fill_line  (r.data),
        .merge_en   (merge_en),
        .merge_line (lane_line),
        .merge_strb (lane_strb),
        .rdata      (rdata)
    );

    cache_controller u_cache_controller (
        .clk      (clk),
        .rst      (rst),
        .r_en     (req.r_en),
        .w_en     (req.w_en),
        .hit      (hit),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_valid  (r.valid),
        .r_ready  (r_ready),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .fill_en  (fill_en),
        .merge_en (merge_en),
        .ready    (ready)
    );

    // struct packing toward the ports
    assign ar  = '{addr: line_addr, valid: ar_valid};
    assign aw  = '{addr: line_addr, valid: aw_valid};
    assign w   = '{data: lane_line, strb: lane_strb, valid: w_valid};
    assign rsp = '{rdata: rdata, ready: ready};

endmodule

`default_nettype wire

// File: hdl/line_store.sv
//################################################
// line store
// 16 x 4 word data array, fill and byte merge
//################################################
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::index_t     index,
    input  cache_pkg::word_sel_t  word_sel,
    input  logic                  fill_en,
    input  cache_pkg::line_t      fill_line,
    input  logic                  merge_en,
    input  cache_pkg::line_t      merge_line,
    input  cache_pkg::line_strb_t merge_strb,
    output cache_pkg::word_t      rdata
);

    localparam int num_lines      = 2 ** cache_pkg::index_w;
    localparam int words_per_line = cache_pkg::words_per_line;
    localparam int bytes_per_word = cache_pkg::word_w / 8;
    localparam int word_w         = cache_pkg::word_w;

    // word 0 sits in the low bits of a bus line
    cache_pkg::word_t mem [num_lines][words_per_line];

    //################################################
    // write side
    //################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < num_lines; l++) begin
                for (int w = 0; w < words_per_line; w++) begin
                    mem[l][w] <= '0;
                end
            end
        end else if (fill_en) begin
            // whole line from the read data channel
            for (int w = 0; w < words_per_line; w++) begin
                mem[index][w] <= fill_line[w*word_w +: word_w];
            end
        end else if (merge_en) begin
            // only strobed bytes change
            for (int w = 0; w < words_per_line; w++) begin
                for (int b = 0; b < bytes_per_word; b++) begin
                    if (merge_strb[w*bytes_per_word + b]) begin
                        mem[index][w][b*8 +: 8] <= merge_line[w*word_w + b*8 +: 8];
                    end
                end
            end
        end
    end

    //################################################
    // read side
    //################################################
    assign rdata = mem[index][word_sel];   // addressed word, no latency

endmodule

`default_nettype wire

// File: hdl/tag_store.sv
//################################################
// tag store
// tag array, valid bits and the hit decision
//################################################
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  logic              fill_en,
    output logic              hit
);

    localparam int num_lines = 2 ** cache_pkg::index_w;

    cache_pkg::tag_t        tags [num_lines];
    logic [num_lines-1:0]   valid;

    // tag written together with the line fill
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;                   // all lines empty
        end else if (fill_en) begin
            valid[index] <= 1'b1;
        end
    end

    // combinational lookup on the live address
    assign hit = valid[index] && (tags[index] == tag);

endmodule

`default_nettype wire

// File: hdl/write_lane.sv
//################################################
// write lane builder
// places a cpu word and its mask in its line slot
//################################################
`timescale 1ns/1ps
`default_nettype none

module write_lane (
    input  cache_pkg::byte_mask_t w_en,
    input  cache_pkg::word_sel_t  word_sel,
    input  cache_pkg::word_t      wdata,
    output cache_pkg::line_t      line,
    output cache_pkg::line_strb_t strb
);

    localparam int bytes_per_word = cache_pkg::word_w / 8;

    cache_pkg::word_t masked;

    always_comb begin
        for (int b = 0; b < bytes_per_word; b++) begin
            masked[b*8 +: 8] = w_en[b] ? wdata[b*8 +: 8] : 8'h00;   // drop unwritten bytes
        end
    end

    // every slot except the addressed one stays zero
    always_comb begin
        line = '0;
        strb = '0;
        for (int s = 0; s < cache_pkg::words_per_line; s++) begin
            if (word_sel == s) begin
                line[s*cache_pkg::word_w +: cache_pkg::word_w] = masked;
                strb[s*bytes_per_word +: bytes_per_word]       = w_en;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/cache_pkg.sv
hdl/write_lane.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/cache_controller.sv
hdl/cache_top.sv
verif/cache_properties.sv
verif/cache_tb.sv

// File: verif/cache_properties.sv
//################################################
// cache controller properties
// handshake rules on the memory side and cpu ready
//################################################
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
    input logic clk,
    input logic rst,
    input logic ar_valid,
    input logic ar_ready,
    input logic aw_valid,
    input logic w_valid,
    input logic ready
);

    int fail_count = 0;   // failed property checks

    ar_held: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid)
        else begin
            $error("ar valid dropped before ar ready");
            fail_count++;
        end

    aw_with_w: assert property (@(posedge clk) disable iff (rst)
        aw_valid == w_valid)
        else begin
            $error("aw valid and w valid differ");
            fail_count++;
        end

    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        ready |=> !ready)
        else begin
            $error("cpu ready high for two cycles");
            fail_count++;
        end

    one_channel: assert property (@(posedge clk) disable iff (rst)
        !(ar_valid && aw_valid))
        else begin
            $error("ar valid and aw valid high together");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: verif/cache_tb.sv
//################################################
// cache testbench
// memory model, directed and random accesses
//################################################
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int num_random = 300;
    localparam int num_txn    = num_random + 20;

    logic                  clk;
    logic                  rst;
    cache_pkg::cpu_req_t   req;
    cache_pkg::cpu_rsp_t   rsp;
    cache_pkg::mem_addr_t  ar;
    cache_pkg::mem_addr_t  aw;
    cache_pkg::mem_rdata_t r;
    cache_pkg::mem_wdata_t w;
    logic                  ar_ready;
    logic                  r_ready;
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic                  b_ready;

    logic [7:0]            mem [65536];        // bus side memory
    logic [7:0]            shadow [65536];     // expected contents
    logic [31:0]           lfsr_state = 32'h44a;
    cache_pkg::tag_t       pred_tag [16];
    logic [15:0]           pred_valid;
    logic                  ar_seen;
    cache_pkg::mem_addr_t  last_ar;
    cache_pkg::mem_addr_t  last_aw;
    cache_pkg::mem_wdata_t last_w;

    cache_top uut (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp),
        .ar(ar), .ar_ready(ar_ready), .r(r), .r_ready(r_ready),
        .aw(aw), .aw_ready(aw_ready), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready)
    );

    bind cache_controller cache_properties u_properties (
        .clk(clk), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .aw_valid(aw_valid), .w_valid(w_valid), .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //################################################
    // reference and helpers
    //################################################
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
        int base;
        base = {a[15:2], 2'b00};
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    function automatic logic predict_hit(input cache_pkg::addr_t a);
        return pred_valid[a[7:4]] && (pred_tag[a[7:4]] == a[15:8]);
    endfunction

    function automatic cache_pkg::mem_wdata_t expected_wdata(input cache_pkg::addr_t a,
            input cache_pkg::byte_mask_t mask, input cache_pkg::word_t wdata);
        cache_pkg::mem_wdata_t e;
        e = '0;
        for (int k = 0; k < 16; k++) begin
            if (k / 4 == int'(a[3:2]) && mask[k % 4]) begin
                e.data[k*8 +: 8] = wdata[(k % 4)*8 +: 8];
                e.strb[k]        = 1'b1;
            end
        end
        e.valid = 1'b1;
        return e;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_word(input string name, input cache_pkg::word_t got,
                                input cache_pkg::word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verify_bus_addr(input string name, input cache_pkg::mem_addr_t got,
                                   input cache_pkg::mem_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_write_data(input string name, input cache_pkg::mem_wdata_t got,
                                    input cache_pkg::mem_wdata_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    //################################################
    // one blocking cpu access
    //################################################
    task automatic run_access(input logic is_write, input cache_pkg::addr_t addr,
                              input cache_pkg::byte_mask_t mask, input cache_pkg::word_t wdata);
        cache_pkg::mem_addr_t exp_addr;
        cache_pkg::word_t     got;
        logic                 exp_hit;
        logic                 seen;
        int                   waited;
        int                   base;
        exp_hit  = predict_hit(addr);
        exp_addr = '{addr: {16'h0000, addr[15:4], 4'h0}, valid: 1'b1};
        base     = {addr[15:2], 2'b00};
        ar_seen  = 1'b0;
        last_ar  = '0;
        last_aw  = '0;
        @(negedge clk);
        req.r_en  = ~is_write;
        req.w_en  = is_write ? mask : 4'h0;
        req.addr  = addr;
        req.wdata = wdata;
        waited    = 0;
        seen      = 1'b0;
        while (!seen) begin
            @(negedge clk);
            #1;                                     // settle after the memory model
            waited++;
            seen = (rsp.ready === 1'b1);
        end
        got = rsp.rdata;
        @(negedge clk);
        req = '0;
        if (is_write) begin
            verify_bus_addr("aw", last_aw, exp_addr);
            check_write_data("w", last_w, expected_wdata(addr, mask, wdata));
            expect_bit("ar.valid rose", ar_seen, 1'b0);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    shadow[base + b] = wdata[b*8 +: 8];
                end
            end
        end else begin
            expect_bit("ar.valid rose", ar_seen, ~exp_hit);
            if (exp_hit && waited != 1) begin
                report_failure($sformatf("read hit at 0x%h took %0d cycles instead of 1",
                                         addr, waited));
            end
            if (!exp_hit) begin
                verify_bus_addr("ar", last_ar, exp_addr);
                pred_tag[addr[7:4]]   = addr[15:8];  // line now allocated
                pred_valid[addr[7:4]] = 1'b1;
            end
            compare_word("rdata", got, expected_word(addr));
        end
    endtask

    //################################################
    // memory model
    //################################################
    initial begin : read_port
        int               delay;
        cache_pkg::addr_t base;
        ar_ready = 1'b0;
        r        = '0;
        forever begin
            @(negedge clk);
            if (!rst && ar.valid === 1'b1) begin
                ar_seen = 1'b1;
                last_ar = ar;
                delay   = rand_bits(2);
                repeat (delay) @(negedge clk);
                ar_ready = 1'b1;
                @(negedge clk);
                ar_ready = 1'b0;
                base     = last_ar.addr[15:0];
                delay    = rand_bits(2);
                repeat (delay) @(negedge clk);
                for (int k = 0; k < 16; k++) begin
                    r.data[k*8 +: 8] = mem[base + k];
                end
                r.valid = 1'b1;
                while (!r_ready) @(negedge clk);
                @(negedge clk);
                r.valid = 1'b0;
            end
        end
    end

    initial begin : write_port
        int delay;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && aw.valid === 1'b1) begin
                last_aw = aw;
                last_w  = w;
                delay   = rand_bits(2);
                repeat (delay) @(negedge clk);
                aw_ready = 1'b1;                   // both together
                w_ready  = 1'b1;
                @(negedge clk);
                aw_ready = 1'b0;
                w_ready  = 1'b0;
                for (int k = 0; k < 16; k++) begin
                    if (last_w.strb[k]) begin
                        mem[last_aw.addr[15:0] + k] = last_w.data[k*8 +: 8];
                    end
                end
                delay = rand_bits(2);
                repeat (delay) @(negedge clk);
                b_valid = 1'b1;
                while (!b_ready) @(negedge clk);
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (200 * num_txn + 20) @(posedge clk);
        report_failure("watchdog timeout, a transaction never completed");
    end

    initial begin : assertion_watch
        wait (uut.u_cache_controller.u_properties.fail_count != 0);
        report_failure("a bound handshake assertion failed");
    end

    //################################################
    // stimulus
    //################################################
    initial begin : stimulus
        logic                  is_write;
        logic [7:0]            pick;
        cache_pkg::byte_mask_t mask;
        cache_pkg::word_t      wdata;
        rst        = 1'b1;
        req        = '0;
        pred_valid = '0;
        ar_seen    = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            mem[a]    = 8'(rand_bits(8));
            shadow[a] = mem[a];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        expect_bit("ar.valid", ar.valid, 1'b0);
        expect_bit("aw.valid", aw.valid, 1'b0);
        expect_bit("w.valid", w.valid, 1'b0);
        expect_bit("r_ready", r_ready, 1'b0);
        expect_bit("b_ready", b_ready, 1'b0);
        expect_bit("rsp.ready", rsp.ready, 1'b0);

        run_access(1'b0, 16'h1234, 4'h0, 32'h0);             // cold miss
        run_access(1'b0, 16'h1238, 4'h0, 32'h0);             // same line hits
        run_access(1'b1, 16'h123c, 4'b0110, 32'hdeadbeef);   // write hit
        run_access(1'b0, 16'h123c, 4'h0, 32'h0);
        run_access(1'b1, 16'h5678, 4'hf, 32'hcafef00d);      // write miss
        run_access(1'b0, 16'h5678, 4'h0, 32'h0);
        for (int i = 0; i < 3; i++) begin
            run_access(1'b0, 16'h0a40, 4'h0, 32'h0);         // same index, other tag
            run_access(1'b0, 16'h1b40, 4'h0, 32'h0);
        end

        // small window of 4 tags so hits and conflicts both occur
        for (int n = 0; n < num_random; n++) begin
            is_write = rand_bits(1) != 0;
            pick     = 8'(rand_bits(8));
            mask     = 4'(rand_bits(4));
            wdata    = rand_bits(32);
            if (mask == 4'h0) begin
                mask = 4'hf;
            end
            run_access(is_write, {6'b001100, pick, 2'b00}, mask, wdata);
        end

        repeat (4) @(negedge clk);
        if (uut.u_cache_controller.u_properties.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure("a bound handshake assertion failed");
        end
    end

endmodule

`default_nettype wire
